// File: build.f
hdl/lock_pkg.sv
hdl/key_decoder.sv
hdl/lockout_timer.sv
hdl/code_entry.sv
hdl/buzzer_tone.sv
hdl/lock_top.sv
dv/lock_tb.sv

// File: Bender.yml
package:
  name: keypad_lock

sources:
  - files:
      - hdl/lock_pkg.sv
      - hdl/key_decoder.sv
      - hdl/lockout_timer.sv
      - hdl/code_entry.sv
      - hdl/buzzer_tone.sv
      - hdl/lock_top.sv
  - target: test
    files:
      - dv/lock_tb.sv

// File: dv/lock_tb.sv
`timescale 1ns/1ps

module lock_tb;
    import lock_pkg::*;

    typedef enum int {M_ENTRY, M_OPEN, M_LOCKED} model_state_t;

    logic         clk;
    logic         rst_n;
    keys_t        keys;
    disp_t        disp;
    tries_t       tries;
    logic         locked;
    logic         unlocked;
    logic         buzzer;

    int           cyc = 0;
    int           lock_cyc = 0;    // cycle the model entered lockout
    int           n_tests = 0;
    int           n_err = 0;
    logic [31:0]  rng_state = 32'd82601;

    // keypad line of key codes 0 to 12
    int           key_line [13] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13, 0, 12, 8};

    model_state_t m_state;
    disp_t        m_disp;
    int           m_cnt;
    tries_t       m_tries;
    logic         m_locked;
    logic         m_unlocked;

    lock_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .keys     (keys),
        .disp     (disp),
        .tries    (tries),
        .locked   (locked),
        .unlocked (unlocked),
        .buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;  // stable when sampled at negedge

    function int next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[30:16]);
    endfunction

    function keys_t key_lines(int code);
        if (code < 0 || code > 12) return '0;
        return keys_t'(1) << key_line[code];
    endfunction

    function int decode_lines(keys_t k);
        for (int c = 0; c <= 12; c++) begin
            if (k == key_lines(c)) return c;
        end
        return 15;                           // idle, multi-hot or unused line
    endfunction

    // biased toward 2/4/6, enter and clear
    function keys_t pick_keys();
        int sel;
        sel = next_rand() % 20;
        if (sel < 5) return key_lines(2 + 2 * (sel % 3));
        else if (sel < 8) return key_lines(10);
        else if (sel < 10) return key_lines(11);
        else if (sel < 12) return key_lines(12);
        else if (sel == 12) return keys_t'(16'h0010);
        else if (sel == 13) return keys_t'(16'h0048);
        else return key_lines(next_rand() % 10);
    endfunction

    // expected display d cycles after the lockout began
    function disp_t lock_disp(int d);
        int v;
        v = 20;
        if (d >= 2) v = 20 - (d - 2) / TICK_CYCLES;  // display trails the timer by a cycle
        if (v < 0) v = 0;
        return {4'h0, nibble_t'(v / 10), nibble_t'(v % 10)};
    endfunction

    task model_reset();
        m_state    = M_ENTRY;
        m_disp     = 12'hfff;
        m_cnt      = 0;
        m_tries    = '0;
        m_locked   = 1'b0;
        m_unlocked = 1'b0;
    endtask

    task model_key(int code);
        if (m_state == M_OPEN && code == 12) begin
            m_disp     = 12'hfff;
            m_unlocked = 1'b0;
            m_state    = M_ENTRY;
        end else if (m_state == M_ENTRY) begin
            if (code <= 9) begin
                if (m_cnt < 3) begin
                    m_disp = {m_disp[7:0], code[3:0]};
                    m_cnt++;
                end
            end else if (code == 10 && m_cnt == 3) begin
                m_cnt = 0;
                if (m_disp == 12'h246) begin
                    m_disp     = 12'ha55;
                    m_tries    = '0;
                    m_unlocked = 1'b1;
                    m_state    = M_OPEN;
                end else if (int'(m_tries) + 1 == MAX_TRIES) begin
                    m_tries  = '0;
                    m_locked = 1'b1;
                    m_state  = M_LOCKED;
                    lock_cyc = cyc;
                end else begin
                    m_disp  = 12'hfff;
                    m_tries = m_tries + 1'b1;
                end
            end else if (code == 11 || code == 12) begin
                m_disp = 12'hfff;
                m_cnt  = 0;
                if (code == 12) m_tries = '0;
            end
        end
    endtask

    task check_disp(string name, disp_t exp, disp_t act);
        n_tests++;
        if (act !== exp) begin
            n_err++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end else begin
            $display("ok    %s %h", name, act);
        end
    endtask

    task check_tries(string name, tries_t exp, tries_t act);
        n_tests++;
        if (act !== exp) begin
            n_err++;
            $display("Error %s expected %0d actual %0d", name, exp, act);
        end else begin
            $display("ok    %s %0d", name, act);
        end
    endtask

    task check_flag(string name, logic exp, logic act);
        n_tests++;
        if (act !== exp) begin
            n_err++;
            $display("Error %s expected %b actual %b", name, exp, act);
        end else begin
            $display("ok    %s %b", name, act);
        end
    endtask

    task check_half(string name, int exp, int act, int tol);
        n_tests++;
        if (act < exp - tol || act > exp + tol) begin
            n_err++;
            $display("Error %s expected %0d actual %0d", name, exp, act);
        end else begin
            $display("ok    %s %0d", name, act);
        end
    endtask

    task report_timeout(string what);
        n_tests++;
        n_err++;
        $display("Timed out waiting for %s", what);
    endtask

    task compare_outputs(string name);
        disp_t exp_disp;
        exp_disp = (m_state == M_LOCKED) ? lock_disp(cyc - lock_cyc) : m_disp;
        check_disp({name, " disp"}, exp_disp, disp);
        check_tries({name, " tries"}, m_tries, tries);
        check_flag({name, " locked"}, m_locked, locked);
        check_flag({name, " unlocked"}, m_unlocked, unlocked);
    endtask

    task idle(int n);
        repeat (n) @(posedge clk);
    endtask

    // drive at t0, outputs settle after t2, release at t0 + hold
    task press(string name, keys_t k, int hold);
        @(posedge clk);
        keys <= k;
        repeat (2) @(posedge clk);
        @(negedge clk);
        model_key(decode_lines(k));
        compare_outputs(name);
        if (hold > 3) begin
            repeat (hold - 3) @(posedge clk);
            @(negedge clk);
            compare_outputs({name, " held"});
        end
        @(posedge clk);
        keys <= '0;
    endtask

    task measure_tone(string name, int half, int len);
        int t;
        int rise;
        int last_high;
        @(negedge clk);
        t = 0;
        while (buzzer !== 1'b1 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (buzzer !== 1'b1) begin
            report_timeout({name, " buzzer rise"});
        end else begin
            rise = cyc;
            t = 0;
            while (buzzer === 1'b1 && t < 20) begin
                @(negedge clk);
                t++;
            end
            check_half({name, " half period"}, half, cyc - rise, 0);
            last_high = rise;
            for (t = 0; t < len + 8; t++) begin
                @(negedge clk);
                if (buzzer === 1'b1) last_high = cyc;
            end
            check_flag({name, " tone ends"}, 1'b1, (last_high - rise) < len + 4);
        end
    endtask

    task wait_unlock(string name);
        int    t;
        logic  bad;
        disp_t bad_exp;
        disp_t bad_act;
        t = 0;
        bad = 1'b0;
        bad_exp = '0;
        bad_act = '0;
        @(negedge clk);
        while (locked === 1'b1 && t < 25 * TICK_CYCLES) begin
            if (!bad && disp !== lock_disp(cyc - lock_cyc)) begin
                bad     = 1'b1;              // first wrong countdown value
                bad_exp = lock_disp(cyc - lock_cyc);
                bad_act = disp;
            end
            @(negedge clk);
            t++;
        end
        if (locked === 1'b1) begin
            report_timeout({name, " end of lockout"});
        end else begin
            // timer starts one cycle after the pulse and locked clears one cycle after 00
            check_half({name, " lockout cycles"}, 20 * TICK_CYCLES + 2, cyc - lock_cyc, 2);
            check_disp({name, " countdown display"}, bad_exp, bad_act);
            m_state  = M_ENTRY;
            m_locked = 1'b0;
            m_disp   = 12'hfff;
            m_cnt    = 0;
            compare_outputs({name, " after lockout"});
        end
    endtask

    task enter_code(string name, int a, int b, int c);
        press({name, " d0"}, key_lines(a), 3);
        idle(12);
        press({name, " d1"}, key_lines(b), 3);
        idle(12);
        press({name, " d2"}, key_lines(c), 3);
        idle(40);                            // let the last click finish
        press({name, " enter"}, key_lines(10), 3);
    endtask

    initial begin
        rst_n = 1'b0;
        keys  = '0;
        model_reset();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        idle(2);
        @(negedge clk);
        compare_outputs("reset");
        check_flag("reset buzzer", 1'b0, buzzer);

        press("digit 2", key_lines(2), 3);
        measure_tone("click", HALF_CLICK, LEN_CLICK);
        idle(12);
        press("digit 4 long hold", key_lines(4), 9);
        idle(12);
        press("digit 6", key_lines(6), 3);
        idle(12);
        press("fourth digit", key_lines(9), 3);
        idle(12);
        press("unused line", keys_t'(16'h0002), 3);
        idle(12);
        press("multi hot", keys_t'(16'h0048), 3);
        idle(12);
        press("clear", key_lines(11), 3);
        idle(12);

        enter_code("correct", 2, 4, 6);
        measure_tone("pass", HALF_PASS, LEN_PASS);
        idle(12);
        press("digit while open", key_lines(3), 3);
        idle(12);
        press("reset open", key_lines(12), 3);
        idle(12);

        enter_code("wrong 1", 1, 2, 3);
        measure_tone("fail", HALF_FAIL, LEN_FAIL);
        idle(12);
        enter_code("wrong 2", 5, 5, 5);
        idle(12);
        press("reset tries", key_lines(12), 3);
        idle(12);
        for (int i = 0; i < 3; i++) begin
            enter_code($sformatf("lockout %0d", i), 1, 1, 1);
            idle(12);
        end
        press("digit while locked", key_lines(2), 3);
        wait_unlock("lockout");
        idle(12);

        for (int i = 0; i < 80; i++) begin
            press($sformatf("random %0d", i), pick_keys(), 3);
            idle(10 + next_rand() % 6);
            if (m_state == M_LOCKED) wait_unlock($sformatf("random %0d", i));
        end

        $display("tests %0d, errors %0d", n_tests, n_err);
        if (n_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: hdl/lock_top.sv
`timescale 1ns/1ps

module lock_top (
    input  logic             clk,
    input  logic             rst_n,
    input  lock_pkg::keys_t  keys,
    output lock_pkg::disp_t  disp,
    output lock_pkg::tries_t tries,
    output logic             locked,
    output logic             unlocked,
    output logic             buzzer
);
    import lock_pkg::*;

    key_t  key_code;
    logic  key_press;
    bcd_t  lock_count;
    logic  lock_running;
    logic  lock_start;
    logic  tone_req;
    tone_t tone_kind;
    logic  tone_ack;

    key_decoder u_key_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .keys      (keys),
        .key_code  (key_code),
        .key_press (key_press)
    );

    lockout_timer u_lockout_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .lock_start   (lock_start),
        .lock_count   (lock_count),
        .lock_running (lock_running)
    );

    code_entry u_code_entry (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_code     (key_code),
        .key_press    (key_press),
        .lock_count   (lock_count),
        .lock_running (lock_running),
        .lock_start   (lock_start),
        .tone_req     (tone_req),
        .tone_kind    (tone_kind),
        .tone_ack     (tone_ack),
        .disp         (disp),
        .tries        (tries),
        .locked       (locked),
        .unlocked     (unlocked)
    );

    buzzer_tone u_buzzer_tone (
        .clk       (clk),
        .rst_n     (rst_n),
        .tone_req  (tone_req),
        .tone_kind (tone_kind),
        .tone_ack  (tone_ack),
        .buzzer    (buzzer)
    );

endmodule

// File: hdl/buzzer_tone.sv
`timescale 1ns/1ps

module buzzer_tone (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tone_req,
    input  lock_pkg::tone_t tone_kind,
    output logic            tone_ack,
    output logic            buzzer
);
    import lock_pkg::*;

    tone_t            kind_q;
    logic             active;
    logic             phase;
    logic [LEN_W-1:0]  len_cnt;
    logic [HALF_W-1:0] half_cnt;
    logic [LEN_W-1:0]  len_last;
    logic [HALF_W-1:0] half_last;
    logic             accept;
    logic             in_gap;

    assign accept = tone_req && !tone_ack;

    always_comb begin
        case (kind_q)
            TONE_PASS: begin
                half_last = HALF_W'(HALF_PASS - 1);
                len_last  = LEN_W'(LEN_PASS - 1);
            end
            TONE_FAIL: begin
                half_last = HALF_W'(HALF_FAIL - 1);
                len_last  = LEN_W'(LEN_FAIL - 1);
            end
            default: begin
                half_last = HALF_W'(HALF_CLICK - 1);
                len_last  = LEN_W'(LEN_CLICK - 1);
            end
        endcase
    end

    assign in_gap = (kind_q == TONE_FAIL) && (len_cnt >= LEN_W'(FAIL_GAP_LO))
                    && (len_cnt <= LEN_W'(FAIL_GAP_HI));
    assign buzzer = active && phase && !in_gap;

    always_ff @(posedge clk) begin
        if (accept) begin
            kind_q <= tone_kind;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tone_ack <= 1'b0;
            active   <= 1'b0;
            phase    <= 1'b0;
            len_cnt  <= '0;
            half_cnt <= '0;
        end else if (accept) begin
            tone_ack <= 1'b1;
            active   <= 1'b1;   // restarts any tone still playing
            phase    <= 1'b1;
            len_cnt  <= '0;
            half_cnt <= '0;
        end else begin
            if (!tone_req && tone_ack) begin
                tone_ack <= 1'b0;
            end
            if (active) begin
                len_cnt <= len_cnt + 1'b1;
                if (half_cnt == half_last) begin
                    half_cnt <= '0;
                    phase    <= ~phase;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
                if (len_cnt == len_last) begin
                    active <= 1'b0;
                    phase  <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hdl/code_entry.sv
`timescale 1ns/1ps

module code_entry (
    input  logic             clk,
    input  logic             rst_n,
    input  lock_pkg::key_t   key_code,
    input  logic             key_press,
    input  lock_pkg::bcd_t   lock_count,
    input  logic             lock_running,
    output logic             lock_start,
    output logic             tone_req,
    output lock_pkg::tone_t  tone_kind,
    input  logic             tone_ack,
    output lock_pkg::disp_t  disp,
    output lock_pkg::tries_t tries,
    output logic             locked,
    output logic             unlocked
);
    import lock_pkg::*;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKED
    } entry_state_t;

    entry_state_t state;
    logic [1:0]   cnt;          // digits held, 0 to 3
    logic         digit_ok;
    logic         enter_ok;
    logic         code_match;
    logic         ev_valid;
    tone_t        ev_kind;
    logic         hs_idle;
    logic         slot_busy;
    logic         pend_valid;
    tone_t        pend_kind;

    always_comb begin
        digit_ok   = (state == ST_ENTRY) && key_press && (key_code <= 4'd9) && (cnt != 2'd3);
        enter_ok   = (state == ST_ENTRY) && key_press && (key_code == KEY_ENTER) && (cnt == 2'd3);
        code_match = (disp == PASSCODE);
        ev_valid   = digit_ok || enter_ok;
        ev_kind    = digit_ok ? TONE_CLICK : (code_match ? TONE_PASS : TONE_FAIL);
        hs_idle    = !tone_req && !tone_ack;    // previous handshake fully closed
        slot_busy  = pend_valid && !hs_idle;    // slot still full after this cycle
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_ENTRY;
            disp       <= DISP_BLANK;
            cnt        <= 2'd0;
            tries      <= '0;
            locked     <= 1'b0;
            unlocked   <= 1'b0;
            lock_start <= 1'b0;
        end else begin
            lock_start <= 1'b0;
            case (state)
                ST_ENTRY: begin
                    if (digit_ok) begin
                        disp <= {disp[7:0], key_code};  // shift in from the right
                        cnt  <= cnt + 2'd1;
                    end else if (enter_ok) begin
                        cnt <= 2'd0;
                        if (code_match) begin
                            disp     <= PASS_DISP;
                            tries    <= '0;
                            unlocked <= 1'b1;
                            state    <= ST_OPEN;
                        end else if (tries == tries_t'(MAX_TRIES - 1)) begin
                            disp       <= {nibble_t'(0), LOCK_START};
                            tries      <= '0;
                            lock_start <= 1'b1;
                            locked     <= 1'b1;
                            state      <= ST_LOCKED;
                        end else begin
                            disp  <= DISP_BLANK;
                            tries <= tries + 1'b1;
                        end
                    end else if (key_press && key_code == KEY_CLEAR) begin
                        disp <= DISP_BLANK;
                        cnt  <= 2'd0;
                    end else if (key_press && key_code == KEY_RESET) begin
                        disp  <= DISP_BLANK;
                        cnt   <= 2'd0;
                        tries <= '0;
                    end
                end
                ST_OPEN: begin
                    if (key_press && key_code == KEY_RESET) begin
                        disp     <= DISP_BLANK;
                        unlocked <= 1'b0;
                        state    <= ST_ENTRY;
                    end
                end
                ST_LOCKED: begin
                    // timer loads one cycle after the start pulse
                    if (!lock_start) begin
                        if (!lock_running) begin
                            disp   <= DISP_BLANK;
                            locked <= 1'b0;
                            state  <= ST_ENTRY;
                        end else begin
                            disp <= {nibble_t'(0), lock_count};
                        end
                    end
                end
                default: state <= ST_ENTRY;
            endcase
        end
    end

    // four-phase req/ack towards the buzzer, one pending event
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tone_req   <= 1'b0;
            tone_kind  <= TONE_CLICK;
            pend_valid <= 1'b0;
            pend_kind  <= TONE_CLICK;
        end else begin
            if (tone_req && tone_ack) begin
                tone_req <= 1'b0;
            end
            if (hs_idle && pend_valid) begin
                tone_req   <= 1'b1;
                tone_kind  <= pend_kind;
                pend_valid <= 1'b0;
            end
            if (ev_valid) begin
                if (hs_idle && !pend_valid) begin
                    tone_req  <= 1'b1;
                    tone_kind <= ev_kind;
                end else if (!slot_busy || ev_kind != TONE_CLICK) begin
                    pend_valid <= 1'b1;     // pass/fail beats a waiting click
                    pend_kind  <= ev_kind;
                end
            end
        end
    end

endmodule

// File: hdl/lockout_timer.sv
`timescale 1ns/1ps

module lockout_timer (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          lock_start,
    output lock_pkg::bcd_t lock_count,
    output logic          lock_running
);
    import lock_pkg::*;

    logic [TICK_W-1:0] presc;
    logic              tick;
    bcd_t              count_dec;

    assign tick = (presc == TICK_W'(TICK_CYCLES - 1));

    // bcd step down, low digit borrows from the high one
    always_comb begin
        if (lock_count[3:0] == 4'd0) begin
            count_dec = {lock_count[7:4] - 4'd1, 4'd9};
        end else begin
            count_dec = {lock_count[7:4], lock_count[3:0] - 4'd1};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc        <= '0;
            lock_count   <= '0;
            lock_running <= 1'b0;
        end else if (lock_start) begin
            presc        <= '0;         // restart also while running
            lock_count   <= LOCK_START;
            lock_running <= 1'b1;
        end else if (lock_running) begin
            if (tick) begin
                presc      <= '0;
                lock_count <= count_dec;
                if (lock_count == 8'h01) begin
                    lock_running <= 1'b0; // falls together with 00
                end
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

endmodule

// File: hdl/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
    input  logic           clk,
    input  logic           rst_n,
    input  lock_pkg::keys_t keys,
    output lock_pkg::key_t  key_code,
    output logic           key_press
);
    import lock_pkg::*;

    keys_t keys_q;
    key_t  code_cur;
    key_t  code_prev;

    // keypad wiring order, not binary order
    always_comb begin
        case (keys_q)
            16'h0008: code_cur = 4'd0;
            16'h0080: code_cur = 4'd1;
            16'h0040: code_cur = 4'd2;
            16'h0020: code_cur = 4'd3;
            16'h0800: code_cur = 4'd4;
            16'h0400: code_cur = 4'd5;
            16'h0200: code_cur = 4'd6;
            16'h8000: code_cur = 4'd7;
            16'h4000: code_cur = 4'd8;
            16'h2000: code_cur = 4'd9;
            16'h0001: code_cur = KEY_ENTER;
            16'h1000: code_cur = KEY_CLEAR;
            16'h0100: code_cur = KEY_RESET;
            default:  code_cur = KEY_NONE; // idle, multi-hot, unused lines
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            keys_q    <= '0;
            code_prev <= KEY_NONE;
        end else begin
            keys_q    <= keys;
            code_prev <= code_cur;
        end
    end

    assign key_code  = code_cur;
    assign key_press = (code_cur != KEY_NONE) && (code_cur != code_prev); // edge only

endmodule

// File: hdl/lock_pkg.sv
package lock_pkg;

    typedef logic [15:0] keys_t;   // one-hot keypad lines
    typedef logic [3:0]  key_t;    // decoded key code
    typedef logic [3:0]  nibble_t; // one display position
    typedef logic [11:0] disp_t;   // leftmost position in [11:8]
    typedef logic [7:0]  bcd_t;    // two bcd digits
    typedef logic [1:0]  tries_t;

    typedef enum logic [1:0] {
        TONE_CLICK,
        TONE_PASS,
        TONE_FAIL
    } tone_t;

    localparam key_t KEY_ENTER = 4'd10;
    localparam key_t KEY_CLEAR = 4'd11;
    localparam key_t KEY_RESET = 4'd12;
    localparam key_t KEY_NONE  = 4'd15;

    localparam nibble_t NIB_BLANK = 4'hf;
    localparam nibble_t NIB_A     = 4'ha;   // "S" shows as 5

    localparam disp_t DISP_BLANK = {3{NIB_BLANK}};
    localparam disp_t PASSCODE   = 12'h246;
    localparam disp_t PASS_DISP  = {NIB_A, 4'h5, 4'h5};

    localparam int   MAX_TRIES   = 3;
    localparam bcd_t LOCK_START  = 8'h20;
    localparam int   TICK_CYCLES = 16;      // scaled down for simulation
    localparam int   TICK_W      = $clog2(TICK_CYCLES);

    localparam int HALF_CLICK  = 4;
    localparam int HALF_PASS   = 2;
    localparam int HALF_FAIL   = 8;
    localparam int HALF_W      = $clog2(HALF_FAIL);
    localparam int LEN_CLICK   = 32;
    localparam int LEN_PASS    = 96;
    localparam int LEN_FAIL    = 64;
    localparam int LEN_W       = $clog2(LEN_PASS);
    localparam int FAIL_GAP_LO = 24;        // fail tone silent from here
    localparam int FAIL_GAP_HI = 39;        // up to and including here

endpackage
